//--- bench/dcs_stimulus.txt
# id mode sign cycles valid p_pusel p_pdsel n_pusel n_pdsel lock chopen code exp_lock exp_chopen exp_ready
# mode 0 idle, 1 calibrate, 2 calibrate with override; sign 2 is drawn at random
1  0 2    4 0  0  0  0  0 0 0  63 0 0 1
2  1 1  170 0  0  0  0  0 0 0  53 0 0 0
3  1 1  357 0  0  0  0  0 0 0  32 0 0 0
4  1 1   17 0  0  0  0  0 0 0  31 1 0 0
5  1 1  680 0  0  0  0  0 0 0   0 1 0 0
6  1 0 1700 0  0  0  0  0 0 0 100 1 0 0
7  1 0  510 0  0  0  0  0 0 0 123 1 0 0
8  1 0   17 1  5  9 17 21 0 1 123 1 0 0
9  2 0    1 1  5  9 17 21 0 1 123 0 1 1
10 0 2    2 0  0  0  0  0 0 0  63 0 0 1
11 1 1   17 0  0  0  0  0 0 0  62 0 0 0

//--- bench/dcs_tb.sv
/*
  Testbench for dcs_top. Tests come from bench/dcs_stimulus.txt, so the run
  starts in the project root. The comparator is modelled from the chopen output.
*/
`include "dcs_settings.svh"

module dcs_tb
  import dcs_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  // One line of the stimulus file
  typedef struct {
    int                    id;
    int                    mode;          // 0 idle, 1 calibrate, 2 calibrate with override
    logic [1:0]            sign;          // 2 draws a random sign
    int                    cycles;
    logic                  valid;
    logic [`DCS_SEL_W-1:0] p_pusel;
    logic [`DCS_SEL_W-1:0] p_pdsel;
    logic [`DCS_SEL_W-1:0] n_pusel;
    logic [`DCS_SEL_W-1:0] n_pdsel;
    logic                  lock;
    logic                  chopen;
    logic [6:0]            exp_code;
    logic                  exp_lock;
    logic                  exp_chopen;
    logic                  exp_ready;
  } stim_t;

  logic       sys_div_clk = 1'b0;
  logic       rst_n;
  logic       dcs_en;
  logic       duty_gt_50;
  logic       ovrd_sel;
  logic       cfg_valid;
  logic [4:0] cfg_p_pusel;
  logic [4:0] cfg_p_pdsel;
  logic [4:0] cfg_n_pusel;
  logic [4:0] cfg_n_pdsel;
  logic       cfg_lock;
  logic       cfg_chopen;
  logic       cfg_ready;
  logic [4:0] dcc_p_pusel;
  logic [4:0] dcc_p_pdsel;
  logic [4:0] dcc_n_pusel;
  logic [4:0] dcc_n_pdsel;
  logic       dcs_lock;
  logic       chopen;

  stim_t stim_q[$];
  bit    stim_ok;
  int    cycle_limit = 200;               // Margin on top of the summed test lengths
  int    cycle_cnt   = 0;
  int    checks      = 0;
  int    errors      = 0;

  always #2 sys_div_clk = ~sys_div_clk;

  dcs_top u_dut (
    .sys_div_clk (sys_div_clk),
    .rst_n       (rst_n),
    .dcs_en      (dcs_en),
    .duty_gt_50  (duty_gt_50),
    .ovrd_sel    (ovrd_sel),
    .cfg_valid   (cfg_valid),
    .cfg_p_pusel (cfg_p_pusel),
    .cfg_p_pdsel (cfg_p_pdsel),
    .cfg_n_pusel (cfg_n_pusel),
    .cfg_n_pdsel (cfg_n_pdsel),
    .cfg_lock    (cfg_lock),
    .cfg_chopen  (cfg_chopen),
    .cfg_ready   (cfg_ready),
    .dcc_p_pusel (dcc_p_pusel),
    .dcc_p_pdsel (dcc_p_pdsel),
    .dcc_n_pusel (dcc_n_pusel),
    .dcc_n_pdsel (dcc_n_pdsel),
    .dcs_lock    (dcs_lock),
    .chopen      (chopen)
  );

  task automatic check_sel(input string name, input logic [4:0] act, input logic [4:0] exp);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, act, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("[ERROR] %0t %s: got %b, expected %b", $time, name, act, exp);
    end
  endtask

  task automatic check_code(input string name, input dcs_code_t act, input dcs_code_t exp);
    checks++;
    if (act.raw !== exp.raw)
    begin
      errors++;
      $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, act.raw, exp.raw);
    end
  endtask

  // Leg rules: coarse is the upper 5 code bits, fine the lower 2
  task automatic expected_sels(
    input  dcs_code_t  c,
    output logic [4:0] ppu,
    output logic [4:0] ppd,
    output logic [4:0] npu,
    output logic [4:0] npd
  );
    logic [4:0] crs;
    logic [1:0] fn;
    crs = c.raw[6:2];
    fn  = c.raw[1:0];
    ppu = ~crs;
    ppd = (fn == 2'd3) ? ~crs - 5'd1 : ~crs;
    npu = (fn >= 2'd2) ? crs + 5'd1 : crs;
    npd = (fn != 2'd0) ? crs + 5'd1 : crs;
  endtask

  task automatic read_stimulus();
    int    fd;
    int    n;
    int    f[15];
    string line;
    stim_t s;
    stim_ok = 1'b0;
    fd = $fopen("bench/dcs_stimulus.txt", "r");
    if (fd == 0)
    begin
      $display("Cannot open bench/dcs_stimulus.txt from the current directory");
      return;
    end
    stim_ok = 1'b1;
    while ($fgets(line, fd) != 0)
    begin
      if (line.len() > 0 && line.getc(0) != "#")   // Skip column notes
      begin
        n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                    f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
        if (n == 15)
        begin
          s.id         = f[0];
          s.mode       = f[1];
          s.sign       = 2'(f[2]);
          s.cycles     = f[3];
          s.valid      = 1'(f[4]);
          s.p_pusel    = 5'(f[5]);
          s.p_pdsel    = 5'(f[6]);
          s.n_pusel    = 5'(f[7]);
          s.n_pdsel    = 5'(f[8]);
          s.lock       = 1'(f[9]);
          s.chopen     = 1'(f[10]);
          s.exp_code   = 7'(f[11]);
          s.exp_lock   = 1'(f[12]);
          s.exp_chopen = 1'(f[13]);
          s.exp_ready  = 1'(f[14]);
          cycle_limit += s.cycles;
          stim_q.push_back(s);
        end
        else if (n > 0)
        begin
          $display("Malformed stimulus line: %s", line);
          stim_ok = 1'b0;
        end
      end
    end
    $fclose(fd);
    if (stim_q.size() == 0)
    begin
      $display("Stimulus file holds no tests");
      stim_ok = 1'b0;
    end
  endtask

  task automatic run_test(input stim_t s);
    logic       sign_bit;
    logic [4:0] ppu;
    logic [4:0] ppd;
    logic [4:0] npu;
    logic [4:0] npd;
    dcs_code_t  exp_c;
    int         errs_before;
    errs_before = errors;
    sign_bit    = (s.sign == 2'd2) ? 1'($urandom()) : s.sign[0];
    dcs_en      = (s.mode != 0);
    ovrd_sel    = (s.mode == 2);
    cfg_valid   = s.valid;                // Held for the whole test, stalls while not ready
    cfg_p_pusel = s.p_pusel;
    cfg_p_pdsel = s.p_pdsel;
    cfg_n_pusel = s.n_pusel;
    cfg_n_pdsel = s.n_pdsel;
    cfg_lock    = s.lock;
    cfg_chopen  = s.chopen;
    repeat (s.cycles)
    begin
      @(negedge sys_div_clk);
      duty_gt_50 = sign_bit ^ chopen;     // Both chopper halves then read sign_bit
    end
    exp_c.raw = s.exp_code;
    if (s.mode == 2)
    begin
      ppu = s.p_pusel;
      ppd = s.p_pdsel;
      npu = s.n_pusel;
      npd = s.n_pdsel;
    end
    else
    begin
      expected_sels(exp_c, ppu, ppd, npu, npd);
      check_code("code", u_dut.code, exp_c);
    end
    check_sel("dcc_p_pusel", dcc_p_pusel, ppu);
    check_sel("dcc_p_pdsel", dcc_p_pdsel, ppd);
    check_sel("dcc_n_pusel", dcc_n_pusel, npu);
    check_sel("dcc_n_pdsel", dcc_n_pdsel, npd);
    check_bit("dcs_lock", dcs_lock, s.exp_lock);
    check_bit("chopen", chopen, s.exp_chopen);
    check_bit("cfg_ready", cfg_ready, s.exp_ready);
    $display("Test %0d mode %0d, %0d cycles: %s", s.id, s.mode, s.cycles,
             (errors == errs_before) ? "ok" : "mismatch");
  endtask

  initial
  begin
    $timeformat(-9, 1, " ns", 0);
    rst_n       = 1'b0;
    dcs_en      = 1'b0;
    duty_gt_50  = 1'b0;
    ovrd_sel    = 1'b0;
    cfg_valid   = 1'b0;
    cfg_p_pusel = 5'd0;
    cfg_p_pdsel = 5'd0;
    cfg_n_pusel = 5'd0;
    cfg_n_pdsel = 5'd0;
    cfg_lock    = 1'b0;
    cfg_chopen  = 1'b0;
    void'($urandom(32'haa2d2ab3));
    read_stimulus();
    if (!stim_ok)
    begin
      $display("Stimulus could not be loaded, no test was run");
      $display("Simulation FAILED");
    end
    else
    begin
      repeat (8) @(posedge sys_div_clk);
      @(negedge sys_div_clk);
      rst_n = 1'b1;
      foreach (stim_q[i])
        run_test(stim_q[i]);
      $display("Tests %0d, checks %0d, errors %0d", stim_q.size(), checks, errors);
      if (errors == 0)
        $display("Simulation PASSED");
      else
        $display("Simulation FAILED");
    end
    $finish;
  end

  // Run length guard
  initial
  begin
    while (cycle_cnt < cycle_limit)
    begin
      @(posedge sys_div_clk);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, the tests did not complete", cycle_cnt);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

//--- flist.f
+incdir+source
source/dcs_pkg.sv
source/dcs_ctrl_fsm.sv
source/dcs_window_timer.sv
source/dcs_code_tracker.sv
source/dcs_select_decode.sv
source/dcs_ovrd_regs.sv
source/dcs_top.sv
bench/dcs_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the DCS testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f flist.f --top-module dcs_tb \
  && ./obj_dir/Vdcs_tb | tee /dev/stderr | grep "^Simulation PASSED$" > /dev/null \
  && echo "run.sh: pass" \
  || { echo "run.sh: fail"; exit 1; }

//--- source/dcs_code_tracker.sv
/*
  Correction code tracker. duty_gt_50 must be stable at the sample strobes.
  Code saturates at the settings limits, lock is sticky until run drops.
*/
`include "dcs_settings.svh"

module dcs_code_tracker
  import dcs_pkg::*;
(
  input  logic      sys_div_clk,
  input  logic      rst_n,
  input  logic      run,
  input  logic      duty_gt_50,
  input  logic      chopen_cal,
  input  logic      sample_strobe,
  input  logic      sample_idx,
  input  logic      update_strobe,
  input  logic      win_clear,
  output dcs_code_t code,
  output logic      lock_cal
);

  logic [1:0] comp;                       // One comparator bit per chopper half
  logic [4:0] lock_cnt;
  logic       code_at_min;
  logic       code_at_max;

  assign code_at_min = (code.raw == `DCS_CODE_MIN);
  assign code_at_max = (code.raw == `DCS_CODE_MAX);

  // Chopper polarity removes the comparator offset from the two samples
  always_ff @(posedge sys_div_clk or negedge rst_n)
  begin
    if (!rst_n)
      comp <= 2'b00;
    else if (!run || win_clear)
      comp <= 2'b00;
    else if (sample_strobe)
      comp[sample_idx] <= chopen_cal ^ duty_gt_50;
  end

  // Step only when both halves agree
  always_ff @(posedge sys_div_clk or negedge rst_n)
  begin
    if (!rst_n)
      code.raw <= `DCS_CODE_INIT;
    else if (!run)
      code.raw <= `DCS_CODE_INIT;
    else if (update_strobe)
    begin
      if (comp == 2'b11 && !code_at_min)
        code.raw <= code.raw - 7'd1;      // Duty high in both halves
      else if (comp == 2'b00 && !code_at_max)
        code.raw <= code.raw + 7'd1;      // Duty low in both halves
    end
  end

  // Lock after a fixed number of updates, whatever the steps were
  always_ff @(posedge sys_div_clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      lock_cnt <= 5'd0;
      lock_cal <= 1'b0;
    end
    else if (!run)
    begin
      lock_cnt <= 5'd0;
      lock_cal <= 1'b0;
    end
    else if (update_strobe)
    begin
      if (lock_cnt == `DCS_LOCK_CNT)
        lock_cal <= 1'b1;
      else
        lock_cnt <= lock_cnt + 5'd1;
    end
  end

  a_code_range: assert property (
    @(posedge sys_div_clk) disable iff (!rst_n)
    code.raw <= `DCS_CODE_MAX
  ) else $error("dcs_code_tracker: code %0d above limit", code.raw);

endmodule

//--- source/dcs_ctrl_fsm.sv
/*
  Calibration enable FSM. dcs_en is taken as synchronous to sys_div_clk,
  run follows it with one cycle of delay in both directions.
*/
module dcs_ctrl_fsm
  import dcs_pkg::*;
(
  input  logic sys_div_clk,
  input  logic rst_n,
  input  logic dcs_en,
  output logic run
);

  dcs_state_e state;
  dcs_state_e state_nxt;

  always_ff @(posedge sys_div_clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= ST_START;
    else
      state <= state_nxt;
  end

  always_comb
  begin
    state_nxt = ST_START;                 // Unknown encodings fall back to idle
    case (state)
      ST_START:
        state_nxt = dcs_en ? ST_RUN : ST_START;
      ST_RUN:
        state_nxt = dcs_en ? ST_RUN : ST_START;
      default:
        state_nxt = ST_START;
    endcase
  end

  assign run = (state == ST_RUN);

  // State register only ever holds one of the two defined encodings
  a_state_legal: assert property (
    @(posedge sys_div_clk) disable iff (!rst_n)
    state inside {ST_START, ST_RUN}
  ) else $error("dcs_ctrl_fsm: illegal state encoding %b", state);

endmodule

//--- source/dcs_ovrd_regs.sv
/*
  Software override bank with a valid/ready load. Loads stall while the
  loop owns the outputs; ovrd_sel switches all six outputs at once.
*/
module dcs_ovrd_regs
(
  input  logic       sys_div_clk,
  input  logic       rst_n,
  input  logic       run,
  input  logic       ovrd_sel,
  input  logic       cfg_valid,
  input  logic [4:0] cfg_p_pusel,
  input  logic [4:0] cfg_p_pdsel,
  input  logic [4:0] cfg_n_pusel,
  input  logic [4:0] cfg_n_pdsel,
  input  logic       cfg_lock,
  input  logic       cfg_chopen,
  input  logic [4:0] p_pusel,
  input  logic [4:0] p_pdsel,
  input  logic [4:0] n_pusel,
  input  logic [4:0] n_pdsel,
  input  logic       lock_cal,
  input  logic       chopen_cal,
  output logic       cfg_ready,
  output logic [4:0] dcc_p_pusel,
  output logic [4:0] dcc_p_pdsel,
  output logic [4:0] dcc_n_pusel,
  output logic [4:0] dcc_n_pdsel,
  output logic       dcs_lock,
  output logic       chopen
);

  logic [4:0] ovrd_p_pusel;
  logic [4:0] ovrd_p_pdsel;
  logic [4:0] ovrd_n_pusel;
  logic [4:0] ovrd_n_pdsel;
  logic       ovrd_lock;
  logic       ovrd_chopen;
  logic       cfg_xfer;

  assign cfg_ready = !run || ovrd_sel;    // Blocked only while the loop drives
  assign cfg_xfer  = cfg_valid && cfg_ready;

  always_ff @(posedge sys_div_clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ovrd_p_pusel <= 5'd0;
      ovrd_p_pdsel <= 5'd0;
      ovrd_n_pusel <= 5'd0;
      ovrd_n_pdsel <= 5'd0;
      ovrd_lock    <= 1'b0;
      ovrd_chopen  <= 1'b0;
    end
    else if (cfg_xfer)
    begin
      ovrd_p_pusel <= cfg_p_pusel;
      ovrd_p_pdsel <= cfg_p_pdsel;
      ovrd_n_pusel <= cfg_n_pusel;
      ovrd_n_pdsel <= cfg_n_pdsel;
      ovrd_lock    <= cfg_lock;
      ovrd_chopen  <= cfg_chopen;
    end
  end

  assign dcc_p_pusel = ovrd_sel ? ovrd_p_pusel : p_pusel;
  assign dcc_p_pdsel = ovrd_sel ? ovrd_p_pdsel : p_pdsel;
  assign dcc_n_pusel = ovrd_sel ? ovrd_n_pusel : n_pusel;
  assign dcc_n_pdsel = ovrd_sel ? ovrd_n_pdsel : n_pdsel;
  assign dcs_lock    = ovrd_sel ? ovrd_lock    : lock_cal;
  assign chopen      = ovrd_sel ? ovrd_chopen  : chopen_cal;

  // Stored values only move after an accepted transfer
  a_load_handshake: assert property (
    @(posedge sys_div_clk) disable iff (!rst_n)
    $changed({ovrd_p_pusel, ovrd_p_pdsel, ovrd_n_pusel, ovrd_n_pdsel,
              ovrd_lock, ovrd_chopen}) |-> $past(cfg_valid && cfg_ready)
  ) else $error("dcs_ovrd_regs: override changed without a transfer");

endmodule

//--- source/dcs_pkg.sv
/*
  Types of the DCS calibration core. The code word is read raw for stepping
  and split into coarse and fine fields for the leg decode.
*/
package dcs_pkg;

  // Correction code, one 7-bit word seen two ways
  typedef union packed {
    logic [6:0] raw;            // Unsigned value for up/down stepping
    struct packed {
      logic [4:0] coarse;       // Common part of all four selects
      logic [1:0] fine;         // Spread over the legs as +1/-1 offsets
    } split;
  } dcs_code_t;

  // Calibration control states
  typedef enum logic [1:0] {
    ST_START = 2'b00,           // Idle, code held at the initial value
    ST_RUN   = 2'b01            // Measurement windows running
  } dcs_state_e;

endpackage

//--- source/dcs_select_decode.sv
/*
  Code to leg select decode, purely combinational.
  Select arithmetic wraps at 5 bits, the code range keeps it from doing so.
*/
`include "dcs_settings.svh"

module dcs_select_decode
  import dcs_pkg::*;
(
  input  dcs_code_t                code,
  output logic [`DCS_SEL_W-1:0]    p_pusel,
  output logic [`DCS_SEL_W-1:0]    p_pdsel,
  output logic [`DCS_SEL_W-1:0]    n_pusel,
  output logic [`DCS_SEL_W-1:0]    n_pdsel
);

  logic [`DCS_SEL_W-1:0] coarse;
  logic [`DCS_SEL_W-1:0] coarse_inv;
  logic [1:0]            fine;

  assign coarse     = code.split.coarse;
  assign coarse_inv = ~code.split.coarse; // p legs run opposite to the code
  assign fine       = code.split.fine;

  // Fine steps move one leg at a time, spread over 4 code values
  always_comb
  begin
    p_pusel = coarse_inv;
    p_pdsel = coarse_inv;
    n_pusel = coarse;
    n_pdsel = coarse;
    if (fine == 2'd3)
      p_pdsel = coarse_inv - 5'd1;
    if (fine[1])
      n_pusel = coarse + 5'd1;            // Fine 2 and 3
    if (fine != 2'd0)
      n_pdsel = coarse + 5'd1;
  end

endmodule

//--- source/dcs_settings.svh
/*
  Calibration constants shared by the DCS core. The code range has to fit
  the 7-bit code type, and the window phases have to fit a 5-bit counter.
*/
`ifndef DCS_SETTINGS_SVH
`define DCS_SETTINGS_SVH

// Correction code range and start point
`define DCS_CODE_MIN   7'd0
`define DCS_CODE_MAX   7'd123
`define DCS_CODE_INIT  7'd63

// Last phase of the measurement window, 17 cycles per window
`define DCS_WIN_LAST   5'd16

// Updates counted before lock, lock rises on the update after this count
`define DCS_LOCK_CNT   5'd31

// Width of the leg drive-strength selects
`define DCS_SEL_W      5

`endif

//--- source/dcs_top.sv
/*
  DCS calibration core top. All inputs are synchronous to sys_div_clk;
  the comparator output duty_gt_50 has to be synchronized outside.
*/
module dcs_top
  import dcs_pkg::*;
(
  input  logic       sys_div_clk,
  input  logic       rst_n,
  input  logic       dcs_en,
  input  logic       duty_gt_50,
  input  logic       ovrd_sel,
  input  logic       cfg_valid,
  input  logic [4:0] cfg_p_pusel,
  input  logic [4:0] cfg_p_pdsel,
  input  logic [4:0] cfg_n_pusel,
  input  logic [4:0] cfg_n_pdsel,
  input  logic       cfg_lock,
  input  logic       cfg_chopen,
  output logic       cfg_ready,
  output logic [4:0] dcc_p_pusel,
  output logic [4:0] dcc_p_pdsel,
  output logic [4:0] dcc_n_pusel,
  output logic [4:0] dcc_n_pdsel,
  output logic       dcs_lock,
  output logic       chopen
);

  logic       run;
  logic       chopen_cal;
  logic       sample_strobe;
  logic       sample_idx;
  logic       update_strobe;
  logic       win_clear;
  logic       lock_cal;
  dcs_code_t  code;
  logic [4:0] p_pusel;
  logic [4:0] p_pdsel;
  logic [4:0] n_pusel;
  logic [4:0] n_pdsel;

  dcs_ctrl_fsm u_ctrl_fsm (
    .sys_div_clk (sys_div_clk),
    .rst_n       (rst_n),
    .dcs_en      (dcs_en),
    .run         (run)
  );

  dcs_window_timer u_window_timer (
    .sys_div_clk   (sys_div_clk),
    .rst_n         (rst_n),
    .run           (run),
    .chopen_cal    (chopen_cal),
    .sample_strobe (sample_strobe),
    .sample_idx    (sample_idx),
    .update_strobe (update_strobe),
    .win_clear     (win_clear)
  );

  dcs_code_tracker u_code_tracker (
    .sys_div_clk   (sys_div_clk),
    .rst_n         (rst_n),
    .run           (run),
    .duty_gt_50    (duty_gt_50),
    .chopen_cal    (chopen_cal),
    .sample_strobe (sample_strobe),
    .sample_idx    (sample_idx),
    .update_strobe (update_strobe),
    .win_clear     (win_clear),
    .code          (code),
    .lock_cal      (lock_cal)
  );

  dcs_select_decode u_select_decode (
    .code    (code),
    .p_pusel (p_pusel),
    .p_pdsel (p_pdsel),
    .n_pusel (n_pusel),
    .n_pdsel (n_pdsel)
  );

  dcs_ovrd_regs u_ovrd_regs (
    .sys_div_clk (sys_div_clk),
    .rst_n       (rst_n),
    .run         (run),
    .ovrd_sel    (ovrd_sel),
    .cfg_valid   (cfg_valid),
    .cfg_p_pusel (cfg_p_pusel),
    .cfg_p_pdsel (cfg_p_pdsel),
    .cfg_n_pusel (cfg_n_pusel),
    .cfg_n_pdsel (cfg_n_pdsel),
    .cfg_lock    (cfg_lock),
    .cfg_chopen  (cfg_chopen),
    .p_pusel     (p_pusel),
    .p_pdsel     (p_pdsel),
    .n_pusel     (n_pusel),
    .n_pdsel     (n_pdsel),
    .lock_cal    (lock_cal),
    .chopen_cal  (chopen_cal),
    .cfg_ready   (cfg_ready),
    .dcc_p_pusel (dcc_p_pusel),
    .dcc_p_pdsel (dcc_p_pdsel),
    .dcc_n_pusel (dcc_n_pusel),
    .dcc_n_pdsel (dcc_n_pdsel),
    .dcs_lock    (dcs_lock),
    .chopen      (chopen)
  );

endmodule

//--- source/dcs_window_timer.sv
/*
  Measurement window timer, 17 phases per window while run is high.
  Strobes are decoded from the phase register and are valid for one cycle.
*/
`include "dcs_settings.svh"

module dcs_window_timer
(
  input  logic sys_div_clk,
  input  logic rst_n,
  input  logic run,
  output logic chopen_cal,
  output logic sample_strobe,
  output logic sample_idx,
  output logic update_strobe,
  output logic win_clear
);

  logic [4:0] phase;
  logic       phase_last;

  assign phase_last = (phase == `DCS_WIN_LAST);

  // Phase counter, parked at 0 while calibration is off
  always_ff @(posedge sys_div_clk or negedge rst_n)
  begin
    if (!rst_n)
      phase <= 5'd0;
    else if (!run)
      phase <= 5'd0;
    else if (phase_last)
      phase <= 5'd0;
    else
      phase <= phase + 5'd1;
  end

  // Chopper flips at the start and the middle of each window
  always_ff @(posedge sys_div_clk or negedge rst_n)
  begin
    if (!rst_n)
      chopen_cal <= 1'b0;
    else if (!run)
      chopen_cal <= 1'b0;
    else if (phase == 5'd0 || phase == 5'd8)
      chopen_cal <= ~chopen_cal;
  end

  // Samples sit late in each chopper half, after the comparator settles
  assign sample_strobe = (phase == 5'd6) || (phase == 5'd14);
  assign sample_idx    = phase[3];        // 0 in the first half, 1 in the second
  assign update_strobe = (phase == 5'd15);
  assign win_clear     = phase_last;

  a_phase_range: assert property (
    @(posedge sys_div_clk) disable iff (!rst_n)
    phase <= `DCS_WIN_LAST
  ) else $error("dcs_window_timer: phase %0d past window end", phase);

  // Sampling, update and clear must never coincide in the tracker
  a_strobe_onehot: assert property (
    @(posedge sys_div_clk) disable iff (!rst_n)
    $onehot0({sample_strobe, update_strobe, win_clear})
  ) else $error("dcs_window_timer: overlapping strobes");

endmodule
